//--- Makefile
# Verilator build and run for the dining hall testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_dining_hall
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the simulator exit code
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+include
rtl/dpp_event_pkg.sv
rtl/dpp_state_pkg.sv
rtl/event_fifo.sv
rtl/philosopher.sv
rtl/dining_table.sv
rtl/dining_hall.sv
verification/tb_dining_hall.sv

//--- include/dpp_macros.svh
`ifndef DPP_MACROS_SVH
`define DPP_MACROS_SVH

// seats around the table
// fork n sits between seat n and seat n-1
`define DPP_N_PHILO 4

// meal length in cycles
// eating is high for exactly this long
`define DPP_EAT_TIME 2

// minimum thinking time in cycles
// appetite is only sampled after this has run out
`define DPP_THINK_TIME 5

// event FIFO depth per seat
// at most one hungry and one done event are outstanding, so 2 covers it
`define DPP_FIFO_DEPTH 2

`endif

//--- rtl/dining_hall.sv
`default_nettype none
`include "dpp_macros.svh"

// top level: one philosopher and one event FIFO per seat, one shared table
module dining_hall
  import dpp_event_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`DPP_N_PHILO-1:0] appetite,  // per-seat level
  output logic [`DPP_N_PHILO-1:0] eating,    // per-seat level
  output logic [`DPP_N_PHILO-1:0] fork_busy  // per-fork level
);

  localparam int N = `DPP_N_PHILO;

  logic [N-1:0] evt_push;   // philosopher -> FIFO
  evt_e         evt_code [N];
  logic [N-1:0] hungry;     // philosopher -> table
  logic [N-1:0] may_eat;    // table -> philosopher
  logic [N-1:0] pop;        // table -> FIFO
  logic [N-1:0] fifo_empty; // FIFO -> table
  evt_e         fifo_data [N];

  for (genvar i = 0; i < N; i++) begin : g_seat
    philosopher u_philo (
      .clk        (clk),
      .reset      (reset),
      .appetite   (appetite[i]),
      .may_eat    (may_eat[i]),
      .event_push (evt_push[i]),
      .event_code (evt_code[i]),
      .hungry     (hungry[i]),
      .eating     (eating[i])
    );

    event_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (evt_push[i]),
      .push_code (evt_code[i]),
      .pop       (pop[i]),
      .data      (fifo_data[i]),
      .empty     (fifo_empty[i])
    );
  end

  dining_table u_table (
    .clk       (clk),
    .reset     (reset),
    .evt_empty (fifo_empty),
    .evt_data  (fifo_data),
    .hungry    (hungry),
    .pop       (pop),
    .may_eat   (may_eat),
    .fork_busy (fork_busy)
  );

endmodule

`default_nettype wire

//--- rtl/dining_table.sv
`default_nettype none
`include "dpp_macros.svh"

// fork arbiter, owns every fork and serves one event per cycle
module dining_table
  import dpp_event_pkg::*;
  import dpp_state_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`DPP_N_PHILO-1:0] evt_empty, // per-seat FIFO empty
  input  evt_e                    evt_data [`DPP_N_PHILO], // per-seat FIFO head
  input  logic [`DPP_N_PHILO-1:0] hungry,
  output logic [`DPP_N_PHILO-1:0] pop,       // one-cycle FIFO pop
  output logic [`DPP_N_PHILO-1:0] may_eat,   // one-cycle grant
  output logic [`DPP_N_PHILO-1:0] fork_busy
);

  localparam int N  = `DPP_N_PHILO;
  localparam int SW = (N > 1) ? $clog2(N) : 1;

  fork_state_e   fork_st  [N];
  fork_state_e   fork_nxt [N];
  logic [SW-1:0] rr_ptr;    // first seat looked at this cycle
  logic [SW-1:0] sel;       // seat being served
  logic          sel_valid;
  logic [N-1:0]  grant;
  logic [N-1:0]  freed;     // forks released by this cycle's done event

  // seat n eats with fork n and fork left_of(n)
  function automatic int left_of(input int n);
    return (n + 1) % N;
  endfunction

  function automatic int right_of(input int n);
    return (n + N - 1) % N;
  endfunction

  // round-robin pick, skipping a FIFO whose head is being popped right now
  always_comb begin
    int idx;
    sel_valid = 1'b0;
    sel       = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(rr_ptr) + k) % N;
      if (!sel_valid && !evt_empty[idx] && !pop[idx]) begin
        sel_valid = 1'b1;
        sel       = SW'(idx);
      end
    end
  end

  // fork update and grants for the selected event
  always_comb begin
    int s, lf, lf2, rt;
    s        = int'(sel);
    lf       = left_of(s);
    lf2      = left_of(lf); // left fork of the left neighbour
    rt       = right_of(s);
    fork_nxt = fork_st;
    grant    = '0;
    freed    = '0;
    if (sel_valid) begin
      if (evt_data[sel] == evt_hungry) begin
        // both forks or nothing; a refused seat is retried when a neighbour finishes
        if (hungry[s] && fork_st[s] == fork_avail && fork_st[lf] == fork_avail) begin
          fork_nxt[s]  = fork_taken;
          fork_nxt[lf] = fork_taken;
          grant[s]     = 1'b1;
        end
      end else begin
        fork_nxt[s]  = fork_avail;
        fork_nxt[lf] = fork_avail;
        freed[s]     = 1'b1;
        freed[lf]    = 1'b1;
        // right neighbour first, it wants fork rt and our right fork
        if (hungry[rt] && fork_nxt[rt] == fork_avail && fork_nxt[s] == fork_avail) begin
          fork_nxt[rt] = fork_taken;
          fork_nxt[s]  = fork_taken;
          grant[rt]    = 1'b1;
        end
        // then left neighbour, sees the right grant through fork_nxt
        if (hungry[lf] && fork_nxt[lf] == fork_avail && fork_nxt[lf2] == fork_avail) begin
          fork_nxt[lf]  = fork_taken;
          fork_nxt[lf2] = fork_taken;
          grant[lf]     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fork_st <= '{default: fork_avail};
      rr_ptr  <= '0;
      pop     <= '0;
      may_eat <= '0;
    end else begin
      fork_st <= fork_nxt;
      may_eat <= grant;   // decision and pop land on the same edge
      pop     <= '0;
      if (sel_valid) begin
        pop[sel] <= 1'b1;
        rr_ptr   <= (sel == SW'(N - 1)) ? '0 : sel + 1'b1; // next seat gets first look
      end
    end
  end

  for (genvar g = 0; g < N; g++) begin : g_fork
    localparam int GL = (g + 1) % N;

    assign fork_busy[g] = (fork_st[g] == fork_taken);

    // a fork only changes hands when it is free or just released
    a_grant_free: assert property (@(posedge clk) disable iff (reset)
      grant[g] |-> (fork_st[g] == fork_avail || freed[g]) &&
                   (fork_st[GL] == fork_avail || freed[GL]))
      else $error("dining_table: fork granted while taken, seat %0d", g);

    // neighbours share a fork, so never both granted together
    a_no_adjacent: assert property (@(posedge clk) disable iff (reset)
      !(may_eat[g] && may_eat[GL]))
      else $error("dining_table: adjacent grants, seats %0d and %0d", g, GL);

    // done only comes from a seat that holds both its forks
    a_free_taken: assert property (@(posedge clk) disable iff (reset)
      freed[g] |-> fork_st[g] == fork_taken)
      else $error("dining_table: done frees a free fork %0d", g);
  end

endmodule

`default_nettype wire

//--- rtl/dpp_event_pkg.sv
`default_nettype none

// events a philosopher posts to the table
package dpp_event_pkg;

  typedef enum logic {
    evt_hungry = 1'b0, // seat wants both forks
    evt_done   = 1'b1  // meal over, give both forks back
  } evt_e;

endpackage

`default_nettype wire

//--- rtl/dpp_state_pkg.sv
`default_nettype none

// state encodings for seats and forks
package dpp_state_pkg;

  typedef enum logic [1:0] {
    st_thinking = 2'd0,
    st_hungry   = 2'd1, // event posted, waiting for may_eat
    st_eating   = 2'd2
  } philo_state_e;

  typedef enum logic {
    fork_avail = 1'b0,
    fork_taken = 1'b1
  } fork_state_e;

endpackage

`default_nettype wire

//--- rtl/event_fifo.sv
`default_nettype none
`include "dpp_macros.svh"

// per-seat event queue between a philosopher and the table
module event_fifo
  import dpp_event_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic push,      // one-cycle strobe from the philosopher
  input  evt_e push_code,
  input  logic pop,       // one-cycle strobe from the table
  output evt_e data,      // head of queue, valid while !empty
  output logic empty
);

  localparam int DEPTH = `DPP_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  evt_e          mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count; // entries held
  logic          full;
  logic          do_push;
  logic          do_pop;

  // wrap at DEPTH, works for any depth not only powers of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign data    = mem[rd_ptr]; // head shows the cycle after its push

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_code;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  // philosopher never has more than DEPTH events pending
  a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
    else $error("event_fifo: push while full");
  // table only pops a head it has seen
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
    else $error("event_fifo: pop while empty");

endmodule

`default_nettype wire

//--- rtl/philosopher.sv
`default_nettype none
`include "dpp_macros.svh"

// one seat: think, get hungry when appetite allows, eat when granted
module philosopher
  import dpp_event_pkg::*;
  import dpp_state_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic appetite,   // external level, gates think -> hungry
  input  logic may_eat,    // one-cycle grant from the table
  output logic event_push, // one-cycle strobe into own FIFO
  output evt_e event_code, // valid with event_push
  output logic hungry,     // level, high in st_hungry
  output logic eating      // level, high in st_eating
);

  localparam int TMAX = (`DPP_THINK_TIME > `DPP_EAT_TIME) ? `DPP_THINK_TIME : `DPP_EAT_TIME;
  localparam int TW   = (TMAX > 1) ? $clog2(TMAX) : 1; // holds TMAX-1

  // timer counts down to zero, so load one less than the wanted length
  localparam logic [TW-1:0] THINK_LOAD = TW'(`DPP_THINK_TIME - 1);
  localparam logic [TW-1:0] EAT_LOAD   = TW'(`DPP_EAT_TIME - 1);

  philo_state_e  state;
  logic [TW-1:0] timer;     // shared by think and eat phases
  logic          post_hungry;
  logic          post_done;

  // the two ways an event gets raised
  assign post_hungry = (state == st_thinking) && (timer == '0) && appetite;
  assign post_done   = (state == st_eating) && (timer == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= st_thinking;
      timer      <= '0;   // first think after reset is not timed
      event_push <= 1'b0;
    end else begin
      event_push <= post_hungry || post_done; // high in the first cycle of the new state
      case (state)
        st_thinking: begin
          if (timer != '0) begin
            timer <= timer - 1'b1;
          end else if (appetite) begin
            state <= st_hungry; // wait here for appetite, possibly forever
          end
        end
        st_hungry: begin
          if (may_eat) begin
            state <= st_eating;  // eating rises the cycle after the grant
            timer <= EAT_LOAD;
          end
        end
        st_eating: begin
          if (timer != '0) begin
            timer <= timer - 1'b1;
          end else begin
            state <= st_thinking;
            timer <= THINK_LOAD;
          end
        end
        default: state <= st_thinking;
      endcase
    end
  end

  // event payload, only meaningful alongside event_push
  always_ff @(posedge clk) begin
    if (post_hungry) event_code <= evt_hungry;
    else if (post_done) event_code <= evt_done;
  end

  assign hungry = (state == st_hungry);
  assign eating = (state == st_eating);

  // the table must never grant a seat that has not asked
  a_grant_when_hungry: assert property (@(posedge clk) disable iff (reset)
    may_eat |-> state == st_hungry)
    else $error("philosopher: may_eat outside st_hungry");

endmodule

`default_nettype wire

//--- verification/tb_dining_hall.sv
`default_nettype none
`include "dpp_macros.svh"

// random appetite on every seat, cycle-level model watching eating and fork_busy
module tb_dining_hall;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N               = `DPP_N_PHILO;
  localparam int RAND_CYCLES     = 4000; // random appetite phase
  localparam int PROGRESS_LIMIT  = 8 * N * (`DPP_EAT_TIME + `DPP_THINK_TIME);
  localparam int WATCHDOG_CYCLES = RAND_CYCLES + PROGRESS_LIMIT + 200;

  logic         clk = 1'b0;
  logic         reset;
  logic [N-1:0] appetite;
  logic [N-1:0] eating;
  logic [N-1:0] fork_busy;

  integer seed = 68669;

  // reference model, one entry per seat
  int run_len [N];      // cycles of the current meal
  int gap     [N];      // low cycles since the last meal ended
  int meals   [N];
  int hold    [N];      // appetite continuously high while not eating
  bit had_meal [N];
  bit app_seen [N];     // appetite seen high since the last meal ended
  bit prev_eat [N];
  bit prev_reset = 1'b0;
  int max_hold = 0;

  // error counts by kind
  int err_reset = 0;
  int err_mutex = 0;
  int err_fork  = 0;
  int err_meal  = 0;
  int err_gap   = 0;
  int err_app   = 0;
  int err_prog  = 0;

  dining_hall u_dut (
    .clk       (clk),
    .reset     (reset),
    .appetite  (appetite),
    .eating    (eating),
    .fork_busy (fork_busy)
  );

  always #50 clk = ~clk; // 100 ns period

  // monitor on the falling edge, outputs settled by then
  always @(negedge clk) begin
    int nl;
    if (reset || prev_reset) begin // reset and the cycle after it
      if (eating != '0 || fork_busy != '0) begin
        err_reset++;
        $display("[ERROR] %0d ns: outputs busy around reset, eating=%b fork_busy=%b",
                 $time, eating, fork_busy);
      end
    end
    if (reset) begin
      for (int n = 0; n < N; n++) begin
        run_len[n]  = 0;
        gap[n]      = 0;
        meals[n]    = 0;
        hold[n]     = 0;
        had_meal[n] = 1'b0;
        app_seen[n] = 1'b0;
        prev_eat[n] = 1'b0;
      end
    end else begin
      for (int n = 0; n < N; n++) begin
        nl = (n + 1) % N; // left neighbour, also the left fork
        if (eating[n] && eating[nl]) begin
          err_mutex++;
          $display("[ERROR] %0d ns: seats %0d and %0d eat together", $time, n, nl);
        end
        if (eating[n] && !(fork_busy[n] && fork_busy[nl])) begin
          err_fork++;
          $display("[ERROR] %0d ns: seat %0d eats without both forks, fork_busy=%b",
                   $time, n, fork_busy);
        end
        if (eating[n]) begin
          if (!prev_eat[n]) begin // meal starts
            if (had_meal[n] && gap[n] < `DPP_THINK_TIME) begin
              err_gap++;
              $display("[ERROR] %0d ns: seat %0d ate again after %0d cycles, min %0d",
                       $time, n, gap[n], `DPP_THINK_TIME);
            end
            if (!app_seen[n]) begin
              err_app++;
              $display("[ERROR] %0d ns: seat %0d ate with appetite low since last meal",
                       $time, n);
            end
            meals[n]++;
            run_len[n] = 1;
          end else begin
            run_len[n]++;
          end
          hold[n] = 0;
        end else begin
          if (prev_eat[n]) begin // meal just ended
            if (run_len[n] != `DPP_EAT_TIME) begin
              err_meal++;
              $display("[ERROR] %0d ns: seat %0d meal lasted %0d cycles, expected %0d",
                       $time, n, run_len[n], `DPP_EAT_TIME);
            end
            had_meal[n] = 1'b1;
            gap[n]      = 0;
            app_seen[n] = 1'b0;
          end
          gap[n]++;
          if (appetite[n]) app_seen[n] = 1'b1; // value the DUT samples next edge
          hold[n] = appetite[n] ? hold[n] + 1 : 0;
          if (hold[n] > max_hold) max_hold = hold[n];
        end
        prev_eat[n] = eating[n];
      end
    end
    prev_reset = reset;
  end

  // stimulus, checks at the end
  initial begin
    int cycle;
    int total;
    int base [N];
    bit all_ate;
    reset    <= 1'b1;
    appetite <= '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (cycle = 0; cycle < RAND_CYCLES; cycle++) begin
      @(posedge clk);
      for (int i = 0; i < N; i++) begin
        if (((cycle / 256) % N == i) && ((cycle % 256) < 64))
          appetite[i] <= 1'b0; // one seat at a time loses appetite for a stretch
        else
          appetite[i] <= (($random(seed) & 3) != 0); // high three times in four
      end
    end

    // every seat must now get a meal
    @(posedge clk);
    appetite <= '1;
    for (int n = 0; n < N; n++) base[n] = meals[n];
    cycle   = 0;
    all_ate = 1'b0;
    while (!all_ate && cycle < PROGRESS_LIMIT) begin
      @(posedge clk);
      cycle++;
      all_ate = 1'b1;
      for (int n = 0; n < N; n++) begin
        if (meals[n] == base[n]) all_ate = 1'b0;
      end
    end
    for (int n = 0; n < N; n++) begin
      if (meals[n] == base[n]) begin
        err_prog++;
        $display("seat %0d did not eat within %0d cycles of full appetite",
                 n, PROGRESS_LIMIT);
      end
      if (meals[n] == 0) begin
        err_prog++;
        $display("seat %0d never ate during the whole run", n);
      end
    end
    repeat (2) @(posedge clk);

    $display("meals per seat: %p, longest appetite wait %0d cycles", meals, max_hold);
    total = err_reset + err_mutex + err_fork + err_meal + err_gap + err_app + err_prog;
    $display(
      "errors: reset=%0d mutex=%0d forks=%0d meal=%0d gap=%0d appetite=%0d progress=%0d total=%0d",
      err_reset, err_mutex, err_fork, err_meal, err_gap, err_app, err_prog, total);
    if (total == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // last resort if the run never reaches its end
  initial begin
    int waited;
    waited = 0;
    while (waited < WATCHDOG_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
